//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
SIMFLAGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully
SRCS      := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "result: FAIL, run ended early"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/lsu_checker.sv
`include "lsu_defs.svh"

module lsu_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   padv_execute_i,
  input logic                   op_lsu_load_i,
  input logic                   lsu_except_align_o,
  input logic                   lsu_valid_o,
  input logic [`LSU_DATA_W-1:0] lsu_result_o,
  input logic                   dbus_req_o,
  input logic [`LSU_DATA_W-1:0] dbus_adr_o,
  input logic [`LSU_DATA_W-1:0] dbus_dat_o,
  input logic [3:0]             dbus_bsel_o,
  input logic                   dbus_we_o,
  input logic                   dbus_ack_i,
  input logic                   dbus_err_i
);

  int fails = 0; // Failed assertions so far

  // Big endian lane rule where offset 0 is the top byte
  function automatic logic lanes_ok(input logic [3:0] bsel, input logic [1:0] off);
    case (bsel)
      4'b1111, 4'b1100:                   return off == 2'd0;
      4'b0011:                            return off == 2'd2;
      4'b1000, 4'b0100, 4'b0010, 4'b0001: return bsel[2'd3 - off];
      default:                            return 1'b0;
    endcase
  endfunction

  a_no_req_misaligned: assert property (@(posedge clk) disable iff (rst)
    $rose(dbus_req_o) |-> !lsu_except_align_o)
    else begin
      fails++;
      $error("bus request raised for a misaligned access");
    end

  a_bus_stable: assert property (@(posedge clk) disable iff (rst)
    dbus_req_o && !dbus_ack_i && !dbus_err_i |=>
      dbus_req_o && $stable(dbus_adr_o) && $stable(dbus_dat_o) &&
      $stable(dbus_bsel_o) && $stable(dbus_we_o))
    else begin
      fails++;
      $error("bus request dropped or changed before ack");
    end

  a_store_lanes: assert property (@(posedge clk) disable iff (rst)
    dbus_req_o && dbus_we_o |-> lanes_ok(dbus_bsel_o, dbus_adr_o[1:0])) // Loads may fetch 1111
    else begin
      fails++;
      $error("store byte selects break the lane rule");
    end

  a_result_held: assert property (@(posedge clk) disable iff (rst)
    lsu_valid_o && op_lsu_load_i && !padv_execute_i |=> $stable(lsu_result_o))
    else begin
      fails++;
      $error("load result changed while valid was held");
    end

endmodule

//--- bench/lsu_tb.sv
`include "lsu_defs.svh"

module lsu_tb;
  logic        clk = 1'b0;
  logic        rst;
  logic        padv_execute_i;
  logic        pipeline_flush_i;
  logic        dc_enable_i;
  logic [31:0] lsu_adr_i;
  logic [31:0] rfb_i;
  logic [5:0]  opc_insn_i;
  logic        op_lsu_load_i;
  logic        op_lsu_store_i;
  logic [31:0] lsu_result_o;
  logic        lsu_valid_o;
  logic        lsu_except_dbus_o;
  logic        lsu_except_align_o;
  logic [31:0] dbus_adr_o;
  logic [31:0] dbus_dat_o;
  logic [3:0]  dbus_bsel_o;
  logic        dbus_we_o;
  logic        dbus_req_o;
  logic        dbus_ack_i = 1'b0;           // Driven by the memory model only
  logic        dbus_err_i = 1'b0;
  logic [31:0] dbus_dat_i = 32'h0;

  logic [31:0] mem [64];                    // Bus memory preset during reset
  logic [31:0] seed = 32'hc3ccdb6c;
  int          wait_left = 0;               // Cycles until the next response
  logic        inject_err;                  // Answer with err instead of ack
  logic [3:0]  last_bsel = 4'h0;            // Last store seen on the bus
  logic [31:0] last_wdat = 32'h0;
  logic [31:0] last_adr = 32'h0;
  logic [31:0] expect_word;                 // Expected word after stores by lane rule
  logic        saw_req;
  int          err_cnt = 0;
  int          err_mark = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          cycles;

  localparam logic [5:0] ld_ops [6] = '{`LSU_OPC_LBZ, `LSU_OPC_LBS, `LSU_OPC_LHZ,
                                        `LSU_OPC_LHS, `LSU_OPC_LWZ, `LSU_OPC_LWS};

  lsu_top uut (.*);

  bind lsu_top lsu_checker u_checker (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] adr_of(input int widx, input logic [1:0] off);
    return 32'(widx * 4 + int'(off));
  endfunction

  function automatic int size_of(input logic [5:0] opc);
    if (opc == `LSU_OPC_LBZ || opc == `LSU_OPC_LBS || opc == `LSU_OPC_SB)
      return 1;
    if (opc == `LSU_OPC_LHZ || opc == `LSU_OPC_LHS || opc == `LSU_OPC_SH)
      return 2;
    return 4;
  endfunction

  // Addressed lane of a big endian word then extended
  function automatic logic [31:0] load_expect(input logic [5:0] opc, input logic [31:0] word,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[31 - 8 * int'(off) -: 8];
    h = off[1] ? word[15:0] : word[31:16];
    case (opc)
      `LSU_OPC_LBZ: return {24'h0, b};
      `LSU_OPC_LBS: return {{24{b[7]}}, b};
      `LSU_OPC_LHZ: return {16'h0, h};
      `LSU_OPC_LHS: return {{16{h[15]}}, h};
      default:      return word;
    endcase
  endfunction

  // Memory model answers 0 to 3 cycles after it sees the request
  always @(posedge clk) begin
    #20;
    dbus_ack_i = 1'b0;
    dbus_err_i = 1'b0;
    if (rst) begin
      for (int i = 0; i < 64; i++)
        mem[i] = lcg_next();
    end else if (dbus_req_o) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        dbus_err_i = inject_err;
        dbus_ack_i = !inject_err;
        dbus_dat_i = mem[dbus_adr_o[7:2]];
        if (dbus_we_o && !inject_err) begin
          for (int i = 0; i < 4; i++)
            if (dbus_bsel_o[i])
              mem[dbus_adr_o[7:2]][8*i +: 8] = dbus_dat_o[8*i +: 8]; // bsel[3] is the top byte
          last_bsel = dbus_bsel_o;
          last_wdat = dbus_dat_o;
          last_adr  = dbus_adr_o;
        end
        wait_left = int'(lcg_next() >> 30); // High bits since the low ones cycle fast
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("ERR %s expected %08h actual %08h", name, exp, act);
        err_cnt++;
      end
  endtask

  task automatic start_op(input logic [5:0] opc, input logic [31:0] adr, input logic [31:0] dat);
    @(posedge clk);
    #10;
    opc_insn_i     = opc;
    lsu_adr_i      = adr;
    rfb_i          = dat;
    op_lsu_store_i = (opc[5:4] == 2'b11); // 0x3x is a store and 0x2x a load
    op_lsu_load_i  = (opc[5:4] == 2'b10);
  endtask

  // Cycles from issue to valid or an exception with bus requests noted
  task automatic wait_end(output int n);
    n       = 0;
    saw_req = 1'b0;
    @(negedge clk);
    while (!(lsu_valid_o || lsu_except_dbus_o || lsu_except_align_o) && n < 20) begin
      saw_req = saw_req | dbus_req_o;
      n++;
      @(negedge clk);
    end
    saw_req = saw_req | dbus_req_o;
    if (n >= 20) begin
      $display("timeout: access at %08h did not end within 20 cycles", lsu_adr_i);
      err_cnt++;
    end
  endtask

  task automatic advance();
    @(posedge clk);
    #10;
    padv_execute_i = 1'b1;
    op_lsu_load_i  = 1'b0;
    op_lsu_store_i = 1'b0;
    @(posedge clk);
    #10;
    padv_execute_i = 1'b0;
  endtask

  task automatic load_check(input string name, input logic [5:0] opc, input int widx,
                            input logic [1:0] off, output int n);
    start_op(opc, adr_of(widx, off), 32'h0);
    wait_end(n);
    check_val(name, 1, 32'(lsu_valid_o));
    check_val(name, load_expect(opc, mem[widx], off), lsu_result_o);
    advance();
  endtask

  task automatic store_check(input string name, input logic [5:0] opc, input int widx,
                             input logic [1:0] off, input logic [31:0] dat);
    logic [3:0]  bsel;
    logic [31:0] wdat;
    int          n;
    case (opc)
      `LSU_OPC_SB: begin
        bsel = 4'b0001 << (3 - int'(off));
        wdat = {4{dat[7:0]}};
      end
      `LSU_OPC_SH: begin
        bsel = (off == 2'd0) ? 4'b1100 : 4'b0011;
        wdat = {2{dat[15:0]}};
      end
      default: begin
        bsel = 4'b1111;
        wdat = dat;
      end
    endcase
    for (int i = 0; i < 4; i++)
      if (bsel[i])
        expect_word[8*i +: 8] = wdat[8*i +: 8];
    start_op(opc, adr_of(widx, off), dat);
    wait_end(n);
    check_val(name, 1, 32'(lsu_valid_o));
    check_val(name, 32'(bsel), 32'(last_bsel));
    check_val(name, wdat, last_wdat);
    check_val(name, adr_of(widx, off), last_adr);
    advance();
  endtask

  task automatic misalign_check(input logic [5:0] opc, input int widx, input logic [1:0] off);
    int n;
    start_op(opc, adr_of(widx, off), 32'h0);
    wait_end(n);
    check_val("misalign", 1, 32'(lsu_except_align_o));
    check_val("misalign", 0, 32'(saw_req));
    advance();
  endtask

  task automatic end_test(input string name);
    int now;
    now = err_cnt + uut.u_checker.fails;
    test_cnt++;
    if (now == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, now - err_mark);
    end
    err_mark = now;
  endtask

  initial begin
    rst              = 1'b1;
    padv_execute_i   = 1'b0;
    pipeline_flush_i = 1'b0;
    dc_enable_i      = 1'b0;
    lsu_adr_i        = 32'h0;
    rfb_i            = 32'h0;
    opc_insn_i       = 6'h0;
    op_lsu_load_i    = 1'b0;
    op_lsu_store_i   = 1'b0;
    inject_err       = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    // Every size and sign mode at each aligned offset with the cache off
    for (int k = 0; k < 6; k++)
      for (int off = 0; off < 4; off += size_of(ld_ops[k]))
        load_check("load_sizes", ld_ops[k], 8 + 4 * k + off, 2'(off), cycles);
    end_test("load_sizes");

    expect_word = mem[40];
    store_check("stores", `LSU_OPC_SW, 40, 2'd0, 32'h11223344);
    store_check("stores", `LSU_OPC_SB, 40, 2'd1, 32'h123456a5); // Only the low byte counts
    store_check("stores", `LSU_OPC_SH, 40, 2'd2, 32'hcafebeef);
    check_val("stores", expect_word, mem[40]);
    load_check("stores", `LSU_OPC_LWZ, 40, 2'd0, cycles);
    end_test("stores");

    misalign_check(`LSU_OPC_LHZ, 44, 2'd1);
    misalign_check(`LSU_OPC_LWS, 44, 2'd2);
    misalign_check(`LSU_OPC_SH, 44, 2'd3);
    misalign_check(`LSU_OPC_SW, 44, 2'd1);
    end_test("misalign");

    inject_err = 1'b1;
    start_op(`LSU_OPC_LWZ, adr_of(50, 2'd0), 32'h0);
    wait_end(cycles);
    inject_err = 1'b0;
    check_val("bus_error", 1, 32'(lsu_except_dbus_o));
    repeat (3) begin
      @(negedge clk);
      check_val("bus_error", 1, 32'(lsu_except_dbus_o)); // Held over the stall
    end
    advance();
    @(negedge clk);
    check_val("bus_error", 0, 32'(lsu_except_dbus_o));
    end_test("bus_error");

    // Miss and fill then hits before and after a write-through store
    dc_enable_i = 1'b1;
    load_check("cache", `LSU_OPC_LWZ, 60, 2'd0, cycles);
    load_check("cache", `LSU_OPC_LWZ, 60, 2'd0, cycles);
    check_val("cache_hit_cycles", 1, cycles);
    check_val("cache_hit_no_req", 0, 32'(saw_req));
    expect_word = mem[60];
    store_check("cache", `LSU_OPC_SB, 60, 2'd3, 32'h0000005a);
    check_val("cache", expect_word, mem[60]);
    load_check("cache", `LSU_OPC_LWZ, 60, 2'd0, cycles);
    check_val("cache_hit_cycles", 1, cycles);
    check_val("cache_hit_no_req", 0, 32'(saw_req));
    dc_enable_i = 1'b0;
    end_test("cache");

    start_op(`LSU_OPC_LHS, adr_of(13, 2'd2), 32'h0);
    wait_end(cycles);
    repeat (4) begin
      @(negedge clk);
      check_val("stall_hold", 1, 32'(lsu_valid_o));
      check_val("stall_hold", load_expect(`LSU_OPC_LHS, mem[13], 2'd2), lsu_result_o);
    end
    advance();
    @(negedge clk);
    check_val("stall_hold", 0, 32'(lsu_valid_o)); // Cleared by the advance
    end_test("stall_hold");

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, fail_cnt, err_cnt, uut.u_checker.fails);
    if (fail_cnt == 0 && err_cnt == 0 && uut.u_checker.fails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- source/dbus_if.sv
`include "lsu_defs.svh"

// Single word access between the access controller and the cache
interface dbus_if;
  logic [`LSU_DATA_W-1:0] adr;   // Byte address
  logic [`LSU_DATA_W-1:0] dat_w; // Replicated store data
  logic [3:0]             bsel;  // Big endian lane selects
  logic                   we;    // Store when high
  logic                   req;   // Held until ack or err
  logic                   ack;   // One cycle pulse
  logic                   err;   // One cycle pulse, never with ack
  logic [`LSU_DATA_W-1:0] dat_r; // Raw read word

  modport master (
    output adr,
    output dat_w,
    output bsel,
    output we,
    output req,
    input  ack,
    input  err,
    input  dat_r
  );

  modport slave (
    input  adr,
    input  dat_w,
    input  bsel,
    input  we,
    input  req,
    output ack,
    output err,
    output dat_r
  );
endinterface

//--- source/dcache_wt.sv
`include "lsu_defs.svh"

module dcache_wt (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dc_enable_i,
  dbus_if.slave                  cpu,
  output logic [`LSU_DATA_W-1:0] dbus_adr_o,
  output logic [`LSU_DATA_W-1:0] dbus_dat_o,
  output logic [3:0]             dbus_bsel_o,
  output logic                   dbus_we_o,
  output logic                   dbus_req_o,
  input  logic                   dbus_ack_i,
  input  logic                   dbus_err_i,
  input  logic [`LSU_DATA_W-1:0] dbus_dat_i
);

  localparam int depth = 1 << `LSU_DC_IDX_W;
  localparam int tag_w = `LSU_DATA_W - `LSU_DC_IDX_W - 2;

  localparam logic [1:0] st_idle = 2'd0; // Waiting for a request
  localparam logic [1:0] st_bus  = 2'd1; // Outgoing access in flight
  localparam logic [1:0] st_resp = 2'd2; // Ack or err pulse to the cpu side

  logic [1:0]               state;
  logic [depth-1:0]         valid;            // Cleared on reset
  logic [tag_w-1:0]         tag_mem [depth];
  logic [`LSU_DATA_W-1:0]   data_mem [depth];
  logic [`LSU_DC_IDX_W-1:0] idx;              // Index of cpu address
  logic [`LSU_DC_IDX_W-1:0] idx_q;            // Index of latched address
  logic [tag_w-1:0]         tag;
  logic                     hit;
  logic                     hit_q;            // Store hit, merge on ack
  logic                     bypass;           // Cache off, bus passes through
  logic                     req_q;            // Registered bus request
  logic                     ack_q;
  logic                     err_q;
  logic                     drop_q;           // Request left during the access
  logic [`LSU_DATA_W-1:0]   adr_q;
  logic [`LSU_DATA_W-1:0]   dat_q;
  logic [`LSU_DATA_W-1:0]   rdat_q;           // Hit or fill word
  logic [3:0]               bsel_q;
  logic                     we_q;

  assign idx    = cpu.adr[`LSU_DC_IDX_W+1:2];
  assign tag    = cpu.adr[`LSU_DATA_W-1:`LSU_DC_IDX_W+2];
  assign idx_q  = adr_q[`LSU_DC_IDX_W+1:2];
  assign hit    = valid[idx] & (tag_mem[idx] == tag);
  assign bypass = !dc_enable_i & (state == st_idle);

  // Control and valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      valid  <= '0;     // Flush on reset
      req_q  <= 1'b0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      drop_q <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      case (state)
        st_idle: begin
          drop_q <= 1'b0;
          if (dc_enable_i & cpu.req) begin
            if (!cpu.we & hit) begin
              ack_q <= 1'b1;  // Load hit, answer next cycle
              state <= st_resp;
            end else begin
              req_q <= 1'b1;  // Miss or store goes out
              state <= st_bus;
            end
          end else if (bypass & cpu.req & cpu.we & dbus_ack_i & hit) begin
            valid[idx] <= 1'b0; // Store past the cache, line now stale
          end
        end
        st_bus: begin
          if (!cpu.req)
            drop_q <= 1'b1;
          if (dbus_ack_i | dbus_err_i) begin
            req_q <= 1'b0;
            ack_q <= dbus_ack_i & !drop_q & cpu.req;
            err_q <= dbus_err_i & !drop_q & cpu.req;
            state <= st_resp;
            if (dbus_err_i)
              valid[idx_q] <= 1'b0; // Never keep a failed line
            else if (!we_q)
              valid[idx_q] <= 1'b1; // Fill done
          end
        end
        st_resp: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Latched access, arrays and read word
  always_ff @(posedge clk) begin
    if ((state == st_idle) & cpu.req) begin
      adr_q  <= cpu.adr;
      dat_q  <= cpu.dat_w;
      bsel_q <= cpu.we ? cpu.bsel : 4'b1111; // Loads fetch the whole word
      we_q   <= cpu.we;
      hit_q  <= hit;
    end
    if ((state == st_idle) & dc_enable_i & cpu.req & !cpu.we & hit)
      rdat_q <= data_mem[idx];
    if ((state == st_bus) & dbus_ack_i) begin
      if (!we_q) begin
        data_mem[idx_q] <= dbus_dat_i;
        tag_mem[idx_q]  <= adr_q[`LSU_DATA_W-1:`LSU_DC_IDX_W+2];
        rdat_q          <= dbus_dat_i;
      end else if (hit_q) begin
        for (int i = 0; i < 4; i++) begin
          if (bsel_q[i])
            data_mem[idx_q][8*i +: 8] <= dat_q[8*i +: 8]; // Merge by lane
        end
      end
    end
  end

  // Outgoing bus, direct when the cache is off
  assign dbus_req_o  = bypass ? cpu.req   : req_q;
  assign dbus_adr_o  = bypass ? cpu.adr   : adr_q;
  assign dbus_dat_o  = bypass ? cpu.dat_w : dat_q;
  assign dbus_bsel_o = bypass ? cpu.bsel  : bsel_q;
  assign dbus_we_o   = bypass ? cpu.we    : we_q;

  assign cpu.ack   = bypass ? dbus_ack_i : ack_q;
  assign cpu.err   = bypass ? dbus_err_i : err_q;
  assign cpu.dat_r = bypass ? dbus_dat_i : rdat_q;

endmodule

//--- source/lsu_access_ctrl.sv
`include "lsu_defs.svh"

module lsu_access_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   padv_execute_i,
  input  logic                   pipeline_flush_i,
  input  logic                   op_lsu_load_i,
  input  logic                   op_lsu_store_i,
  input  logic                   except_align_i,
  input  logic [`LSU_DATA_W-1:0] adr_i,
  input  logic [3:0]             bsel_i,
  input  logic [`LSU_DATA_W-1:0] store_dat_i,
  input  logic [`LSU_DATA_W-1:0] load_dat_i,
  output logic [`LSU_DATA_W-1:0] lsu_result_o,
  output logic                   lsu_valid_o,
  output logic                   lsu_except_dbus_o,
  dbus_if.master                 bus
);

  logic                   access_done; // Ack seen, waiting for advance
  logic                   except_dbus; // Bus error seen, waiting for advance
  logic                   ack_ok;      // Ack for our own request
  logic                   err_ok;      // Error for our own request
  logic [`LSU_DATA_W-1:0] result_q;    // Load result for a stalled writeback

  // One request per instruction, dropped on flush or misalignment
  assign bus.req = (op_lsu_load_i | op_lsu_store_i) & !except_align_i &
                   !access_done & !except_dbus & !pipeline_flush_i;
  assign bus.adr   = adr_i;
  assign bus.dat_w = store_dat_i;
  assign bus.bsel  = bsel_i;
  assign bus.we    = op_lsu_store_i;

  assign ack_ok = bus.ack & bus.req; // Ignore a late ack after a flush
  assign err_ok = bus.err & bus.req;

  always_ff @(posedge clk) begin
    if (rst)
      access_done <= 1'b0;
    else if (padv_execute_i)
      access_done <= 1'b0; // Next instruction
    else if (ack_ok)
      access_done <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst)
      except_dbus <= 1'b0;
    else if (padv_execute_i | pipeline_flush_i)
      except_dbus <= 1'b0;
    else if (err_ok)
      except_dbus <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (ack_ok & op_lsu_load_i)
      result_q <= load_dat_i;
  end

  assign lsu_valid_o       = ack_ok | access_done;
  assign lsu_except_dbus_o = err_ok | except_dbus;
  assign lsu_result_o      = access_done ? result_q : load_dat_i; // Live in the ack cycle

endmodule

//--- source/lsu_bytelane.sv
`include "lsu_defs.svh"

module lsu_bytelane (
  input  logic [`LSU_DATA_W-1:0] lsu_adr_i,
  input  logic [`LSU_DATA_W-1:0] rfb_i,
  input  logic [5:0]             opc_insn_i,
  input  logic                   op_lsu_load_i,
  input  logic                   op_lsu_store_i,
  input  logic [`LSU_DATA_W-1:0] bus_dat_i,
  output logic [3:0]             bsel_o,
  output logic [`LSU_DATA_W-1:0] store_dat_o,
  output logic                   except_align_o,
  output logic [`LSU_DATA_W-1:0] load_dat_o
);

  lsu_pkg::lsu_opc_u      opc;     // Opcode, two views
  lsu_pkg::lsu_size_e     ld_size; // Size from load view
  lsu_pkg::lsu_size_e     st_size; // Size from store view
  lsu_pkg::lsu_size_e     size;    // Size of current access
  logic [`LSU_DATA_W-1:0] aligned; // Addressed lane at top

  assign opc = opc_insn_i;

  // Load size from extend select and zext bit
  always_comb begin
    case ({opc.ld.ext, opc.ld.zext})
      3'b011, 3'b100: ld_size = lsu_pkg::size_byte; // lbz, lbs
      3'b101, 3'b110: ld_size = lsu_pkg::size_half; // lhz, lhs
      default:        ld_size = lsu_pkg::size_word; // lwz, lws
    endcase
  end

  assign st_size = lsu_pkg::lsu_size_e'(opc.st.size); // Field holds the code
  assign size    = op_lsu_store_i ? st_size : ld_size;

  // Big endian lane selects, offset 0 is the top byte
  always_comb begin
    case (size)
      lsu_pkg::size_byte: bsel_o = 4'b1000 >> lsu_adr_i[1:0];
      lsu_pkg::size_half: bsel_o = lsu_adr_i[1] ? 4'b0011 : 4'b1100;
      default:            bsel_o = 4'b1111;
    endcase
    if (!(op_lsu_load_i | op_lsu_store_i))
      bsel_o = 4'b0000; // No access, no lanes
  end

  // Replicate narrow store operands over every lane
  always_comb begin
    case (size)
      lsu_pkg::size_byte: store_dat_o = {(`LSU_DATA_W/8){rfb_i[7:0]}};
      lsu_pkg::size_half: store_dat_o = {(`LSU_DATA_W/16){rfb_i[15:0]}};
      default:            store_dat_o = rfb_i;
    endcase
  end

  // Word needs both low bits clear, half needs bit 0 clear
  assign except_align_o = (op_lsu_load_i | op_lsu_store_i) &
                          (((size == lsu_pkg::size_word) & (|lsu_adr_i[1:0])) |
                           ((size == lsu_pkg::size_half) & lsu_adr_i[0]));

  assign aligned = bus_dat_i << {lsu_adr_i[1:0], 3'b000}; // Lane to the top

  // Zero or sign extend the top lane
  always_comb begin
    case (ld_size)
      lsu_pkg::size_byte:
        load_dat_o = {{(`LSU_DATA_W-8){aligned[`LSU_DATA_W-1] & !opc.ld.zext}},
                      aligned[`LSU_DATA_W-1 -: 8]};
      lsu_pkg::size_half:
        load_dat_o = {{(`LSU_DATA_W-16){aligned[`LSU_DATA_W-1] & !opc.ld.zext}},
                      aligned[`LSU_DATA_W-1 -: 16]};
      default:
        load_dat_o = aligned; // Word, nothing to extend
    endcase
  end

endmodule

//--- source/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Operand and bus width
`define LSU_DATA_W 32

// Cache index bits, 16 lines by default
`define LSU_DC_IDX_W 4

// Load opcodes
`define LSU_OPC_LWZ 6'h21 // Word, zero ext
`define LSU_OPC_LWS 6'h22 // Word, sign ext
`define LSU_OPC_LBZ 6'h23 // Byte, zero ext
`define LSU_OPC_LBS 6'h24 // Byte, sign ext
`define LSU_OPC_LHZ 6'h25 // Half, zero ext
`define LSU_OPC_LHS 6'h26 // Half, sign ext

// Store opcodes, low two bits give the size
`define LSU_OPC_SW 6'h35 // Word store
`define LSU_OPC_SB 6'h36 // Byte store
`define LSU_OPC_SH 6'h37 // Half store

`endif

//--- source/lsu_pkg.sv
package lsu_pkg;

  // Load view of the opcode
  typedef struct packed {
    logic [2:0] hi;   // Major opcode bits
    logic [1:0] ext;  // Extend select
    logic       zext; // Set for zero extend
  } lsu_ld_opc_t;

  // Store view of the opcode
  typedef struct packed {
    logic [3:0] hi;   // Major opcode bits
    logic [1:0] size; // Store size, same code as lsu_size_e
  } lsu_st_opc_t;

  // One opcode word, read through either view
  typedef union packed {
    lsu_ld_opc_t ld;
    lsu_st_opc_t st;
  } lsu_opc_u;

  // Access size, encoded as the store size field
  typedef enum logic [1:0] {
    size_word = 2'b01,
    size_byte = 2'b10,
    size_half = 2'b11
  } lsu_size_e;

endpackage

//--- source/lsu_top.sv
`include "lsu_defs.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   padv_execute_i,
  input  logic                   pipeline_flush_i,
  input  logic                   dc_enable_i,
  input  logic [`LSU_DATA_W-1:0] lsu_adr_i,
  input  logic [`LSU_DATA_W-1:0] rfb_i,
  input  logic [5:0]             opc_insn_i,
  input  logic                   op_lsu_load_i,
  input  logic                   op_lsu_store_i,
  output logic [`LSU_DATA_W-1:0] lsu_result_o,
  output logic                   lsu_valid_o,
  output logic                   lsu_except_dbus_o,
  output logic                   lsu_except_align_o,
  output logic [`LSU_DATA_W-1:0] dbus_adr_o,
  output logic [`LSU_DATA_W-1:0] dbus_dat_o,
  output logic [3:0]             dbus_bsel_o,
  output logic                   dbus_we_o,
  output logic                   dbus_req_o,
  input  logic                   dbus_ack_i,
  input  logic                   dbus_err_i,
  input  logic [`LSU_DATA_W-1:0] dbus_dat_i
);

  dbus_if lsu_bus (); // Access controller to cache

  logic [3:0]             bsel;      // Lane selects
  logic [`LSU_DATA_W-1:0] store_dat; // Replicated store operand
  logic [`LSU_DATA_W-1:0] load_dat;  // Aligned and extended read word

  lsu_bytelane u_bytelane (
    .lsu_adr_i      (lsu_adr_i),
    .rfb_i          (rfb_i),
    .opc_insn_i     (opc_insn_i),
    .op_lsu_load_i  (op_lsu_load_i),
    .op_lsu_store_i (op_lsu_store_i),
    .bus_dat_i      (lsu_bus.dat_r),
    .bsel_o         (bsel),
    .store_dat_o    (store_dat),
    .except_align_o (lsu_except_align_o),
    .load_dat_o     (load_dat)
  );

  lsu_access_ctrl u_access (
    .clk               (clk),
    .rst               (rst),
    .padv_execute_i    (padv_execute_i),
    .pipeline_flush_i  (pipeline_flush_i),
    .op_lsu_load_i     (op_lsu_load_i),
    .op_lsu_store_i    (op_lsu_store_i),
    .except_align_i    (lsu_except_align_o),
    .adr_i             (lsu_adr_i),
    .bsel_i            (bsel),
    .store_dat_i       (store_dat),
    .load_dat_i        (load_dat),
    .lsu_result_o      (lsu_result_o),
    .lsu_valid_o       (lsu_valid_o),
    .lsu_except_dbus_o (lsu_except_dbus_o),
    .bus               (lsu_bus.master)
  );

  dcache_wt u_dcache (
    .clk         (clk),
    .rst         (rst),
    .dc_enable_i (dc_enable_i),
    .cpu         (lsu_bus.slave),
    .dbus_adr_o  (dbus_adr_o),
    .dbus_dat_o  (dbus_dat_o),
    .dbus_bsel_o (dbus_bsel_o),
    .dbus_we_o   (dbus_we_o),
    .dbus_req_o  (dbus_req_o),
    .dbus_ack_i  (dbus_ack_i),
    .dbus_err_i  (dbus_err_i),
    .dbus_dat_i  (dbus_dat_i)
  );

endmodule

//--- tb.f
+incdir+source
source/lsu_pkg.sv
source/dbus_if.sv
source/lsu_bytelane.sv
source/lsu_access_ctrl.sv
source/dcache_wt.sv
source/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv
